//--- vcfg_cluster.f
+incdir+common
common/vcfg_pkg.sv
common/vcsr_req_if.sv
verilog/vcfg_decoder.sv
vcsr/vcsr_unit.sv
verilog/vcsr_readback.sv
verilog/vcfg_cluster.sv
tests/vcfg_cluster_tb.sv

//--- tests/vcfg_cluster_tb.sv
// Testbench for the vector configuration cluster
// Table-driven requests, a behavioural model and a random back-to-back burst
`timescale 1ns/1ps
`include "vcfg_macros.svh"

module vcfg_cluster_tb;
  import vcfg_pkg::*;

  localparam int N_RAND = 40;
  // vtype CSR word after reset or an illegal request
  localparam logic [31:0] VTYPE_WORD_ILL = 32'h8000_0000;

  typedef struct packed {
    logic [31:0]             instr;
    logic [`VCFG_HART_W-1:0] hart;
    logic [31:0]             rs1;
    logic [31:0]             rs2;
    logic [`VCFG_HART_W-1:0] rd_hart;
  } step_t;

  logic                    clk = 1'b0;
  logic                    arst_n;
  logic                    instr_valid;
  logic [31:0]             instr;
  logic [`VCFG_HART_W-1:0] hart_id;
  logic [31:0]             rs1;
  logic [31:0]             rs2;
  logic [`VCFG_HART_W-1:0] rd_hart;
  logic [31:0]             vtype;
  vlen_t                   vl;
  vlen_t                   vstart;

  step_t  steps [$];
  logic   table_ready = 1'b0;
  integer seed = 21122;
  int     errors = 0;
  int     checks = 0;

  // Reference state per hart with vtype held as the CSR word
  logic [31:0] m_vtype  [`VCFG_N_HARTS];
  vlen_t       m_vl     [`VCFG_N_HARTS];
  vlen_t       m_vstart [`VCFG_N_HARTS];

  vcfg_cluster vcfg_cluster_inst (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .hart_id_i     (hart_id),
    .rs1_i         (rs1),
    .rs2_i         (rs2),
    .rd_hart_i     (rd_hart),
    .vtype_o       (vtype),
    .vl_o          (vl),
    .vstart_o      (vstart)
  );

  always #50 clk = ~clk;

  function automatic logic [7:0] vt_byte(input logic [2:0] sew, input logic [2:0] lmul);
    return {2'b00, sew, lmul};
  endfunction

  function automatic logic [31:0] enc_vsetvli(input logic [4:0] rd, input logic [4:0] rs1f,
                                              input logic [7:0] zimm);
    return {4'b0000, zimm, rs1f, 3'd7, rd, 7'h57};
  endfunction

  function automatic logic [31:0] enc_vsetvl(input logic [4:0] rd, input logic [4:0] rs1f);
    return {7'b1000000, 5'd2, rs1f, 3'd7, rd, 7'h57};
  endfunction

  function automatic logic [31:0] enc_csr(input logic [2:0] f3, input logic [11:0] addr,
                                          input logic [4:0] rs1f);
    return {addr, rs1f, f3, 5'd0, 7'h73};
  endfunction

  // LMUL as a fraction num/den
  task automatic lmul_frac(input logic [2:0] code, output int num, output int den);
    num = 1;
    den = 1;
    case (code)
      3'd1: num = 2;
      3'd2: num = 4;
      3'd3: num = 8;
      3'd5: den = 8;
      3'd6: den = 4;
      3'd7: den = 2;
      default: num = 1;
    endcase
  endtask

  task automatic model_step(input logic [31:0] iw, input logic [1:0] h,
                            input logic [31:0] op1, input logic [31:0] op2);
    logic [7:0]  vt;
    logic [31:0] avl;
    logic [31:0] vlmax;
    logic        keep;
    int          sew, num, den, osew, onum, oden;
    if (iw[6:0] == 7'h57 && iw[14:12] == 3'd7 && (!iw[31] || iw[30:25] == 6'd0)) begin
      vt   = iw[31] ? op2[7:0] : iw[27:20];
      keep = (iw[19:15] == 5'd0) && (iw[11:7] == 5'd0);
      avl  = (iw[19:15] == 5'd0) ? 32'hffff_ffff : op1;
      sew  = 8 << vt[5:3];
      osew = 8 << m_vtype[h][5:3];
      lmul_frac(vt[2:0], num, den);
      lmul_frac(m_vtype[h][2:0], onum, oden);
      m_vstart[h] = '0;
      if (vt[5:3] > 3'd2 || vt[2:0] == 3'd4 || sew * den > `VCFG_ELEN * num ||
          (keep && sew * den * onum != osew * oden * num)) begin
        m_vtype[h] = VTYPE_WORD_ILL;
        m_vl[h]    = '0;
      end else begin
        m_vtype[h] = {24'd0, vt};
        vlmax = 32'((`VCFG_VLENB * 8 / sew) * num / den);
        if (!keep) begin
          m_vl[h] = vlen_t'((avl < vlmax) ? avl : vlmax);
        end
      end
    end else if (iw[6:0] == 7'h73 && iw[31:20] == 12'h008) begin
      case (iw[14:12])
        3'd1: m_vstart[h] = vlen_t'(op1);
        3'd2: m_vstart[h] = m_vstart[h] | vlen_t'(op1);
        3'd3: m_vstart[h] = m_vstart[h] & ~vlen_t'(op1);
        default: m_vstart[h] = m_vstart[h];
      endcase
    end
  endtask

  task automatic check_vtype(input logic [31:0] exp);
    checks++;
    if (vtype !== exp) begin
      errors++;
      $display("FAILED vtype_o hart %0d: got 0x%08h, expected 0x%08h", rd_hart, vtype, exp);
    end
  endtask

  task automatic check_vl(input vlen_t exp);
    checks++;
    if (vl !== exp) begin
      errors++;
      $display("FAILED vl_o hart %0d: got 0x%03h, expected 0x%03h", rd_hart, vl, exp);
    end
  endtask

  task automatic check_vstart(input vlen_t exp);
    checks++;
    if (vstart !== exp) begin
      errors++;
      $display("FAILED vstart_o hart %0d: got 0x%03h, expected 0x%03h", rd_hart, vstart, exp);
    end
  endtask

  // Ends any request and compares one hart against the model
  task automatic read_hart(input logic [1:0] h);
    @(negedge clk);
    instr_valid = 1'b0;
    rd_hart     = h;
    #25;
    check_vtype(m_vtype[h]);
    check_vl(m_vl[h]);
    check_vstart(m_vstart[h]);
  endtask

  task automatic read_all_harts();
    for (int h = 0; h < `VCFG_N_HARTS; h++) begin
      read_hart(h[1:0]);
    end
  endtask

  task automatic add_step(input logic [31:0] iw, input logic [1:0] h, input logic [31:0] op1,
                          input logic [31:0] op2, input logic [1:0] rh);
    step_t s;
    s.instr   = iw;
    s.hart    = h;
    s.rs1     = op1;
    s.rs2     = op2;
    s.rd_hart = rh;
    steps.push_back(s);
  endtask

  task automatic drive_request(input logic [31:0] iw, input logic [1:0] h,
                               input logic [31:0] op1, input logic [31:0] op2);
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = iw;
    hart_id     = h;
    rs1         = op1;
    rs2         = op2;
    model_step(iw, h, op1, op2);
  endtask

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = (2 * steps.size() + N_RAND + 2 * `VCFG_N_HARTS + 20) * 100;
    #(limit);
    $display("Timeout: the run did not finish within %0d ns", limit);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    logic [2:0]  r_sew;
    logic [2:0]  r_lmul;
    logic [1:0]  r_hart;
    logic [31:0] r_avl;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    hart_id     = '0;
    rs1         = '0;
    rs2         = '0;
    rd_hart     = '0;
    for (int h = 0; h < `VCFG_N_HARTS; h++) begin
      m_vtype[h]  = VTYPE_WORD_ILL;
      m_vl[h]     = '0;
      m_vstart[h] = '0;
    end

    // Legal vsetvli and VLMAX requests
    add_step(enc_vsetvli(5'd1, 5'd10, vt_byte(3'd0, 3'd0)), 2'd0, 32'd20, 32'd0, 2'd0);
    add_step(enc_vsetvli(5'd1, 5'd10, vt_byte(3'd1, 3'd1)), 2'd1, 32'd100, 32'd0, 2'd1);
    add_step(enc_vsetvli(5'd1, 5'd0, vt_byte(3'd2, 3'd3)), 2'd2, 32'd5, 32'd0, 2'd2);
    add_step(enc_vsetvli(5'd1, 5'd10, 8'hc0 | vt_byte(3'd0, 3'd7)), 2'd3, 32'd7, 32'd0, 2'd3);
    // vstart CSR writes, then one to another CSR
    add_step(enc_csr(3'd1, 12'h008, 5'd3), 2'd0, 32'h0a5, 32'd0, 2'd0);
    add_step(enc_csr(3'd2, 12'h008, 5'd3), 2'd0, 32'h100, 32'd0, 2'd0);
    add_step(enc_csr(3'd3, 12'h008, 5'd3), 2'd0, 32'h005, 32'd0, 2'd0);
    add_step(enc_csr(3'd1, 12'h009, 5'd3), 2'd0, 32'h1ff, 32'd0, 2'd0);
    // vsetvl with vtype in rs2
    add_step(enc_vsetvl(5'd1, 5'd10), 2'd0, 32'd40, vt_byte(3'd1, 3'd2), 2'd0);
    add_step(enc_vsetvl(5'd1, 5'd0), 2'd1, 32'd3, vt_byte(3'd0, 3'd3), 2'd1);
    // Illegal vtypes
    add_step(enc_vsetvli(5'd1, 5'd10, vt_byte(3'd3, 3'd0)), 2'd2, 32'd8, 32'd0, 2'd2);
    add_step(enc_vsetvli(5'd1, 5'd10, vt_byte(3'd0, 3'd4)), 2'd3, 32'd8, 32'd0, 2'd3);
    add_step(enc_vsetvli(5'd1, 5'd10, vt_byte(3'd2, 3'd5)), 2'd3, 32'd8, 32'd0, 2'd3);
    // keep_vl at the same ratio, then at a different one
    add_step(enc_vsetvli(5'd0, 5'd0, vt_byte(3'd0, 3'd1)), 2'd0, 32'd9, 32'd0, 2'd0);
    add_step(enc_vsetvli(5'd0, 5'd0, vt_byte(3'd2, 3'd1)), 2'd0, 32'd9, 32'd0, 2'd0);
    add_step(enc_csr(3'd1, 12'h008, 5'd4), 2'd2, 32'h033, 32'd0, 2'd2);
    table_ready = 1'b1;

    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    read_all_harts();

    foreach (steps[i]) begin
      drive_request(steps[i].instr, steps[i].hart, steps[i].rs1, steps[i].rs2);
      read_hart(steps[i].rd_hart);
    end

    // Back-to-back random requests at one per cycle
    for (int n = 0; n < N_RAND; n++) begin
      r_hart = 2'($unsigned($random(seed)) % `VCFG_N_HARTS);
      r_sew  = 3'($unsigned($random(seed)) % 4);
      r_lmul = 3'($unsigned($random(seed)) % 8);
      r_avl  = $unsigned($random(seed)) % 300;
      drive_request(enc_vsetvli(5'd1, 5'd10, vt_byte(r_sew, r_lmul)), r_hart, r_avl, 32'd0);
    end
    read_all_harts();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog/vcfg_cluster.sv
// Vector configuration cluster
// Decoder, one CSR unit per hart and a readback port for one hart
`timescale 1ns/1ps
`include "vcfg_macros.svh"

module vcfg_cluster (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    instr_valid_i,
  input  logic [31:0]             instr_i,
  input  logic [`VCFG_HART_W-1:0] hart_id_i,
  input  logic [31:0]             rs1_i,
  input  logic [31:0]             rs2_i,
  input  logic [`VCFG_HART_W-1:0] rd_hart_i,
  output logic [31:0]             vtype_o,
  output logic [`VCFG_VL_W-1:0]   vl_o,
  output logic [`VCFG_VL_W-1:0]   vstart_o
);
  import vcfg_pkg::*;

  rvv_instr_u               instr;
  logic [`VCFG_N_HARTS-1:0] req_valid;
  vtype_t                   hart_vtype  [`VCFG_N_HARTS];
  vlen_t                    hart_vl     [`VCFG_N_HARTS];
  vlen_t                    hart_vstart [`VCFG_N_HARTS];

  vcsr_req_if req_if ();

  assign instr = instr_i;

  vcfg_decoder vcfg_decoder_inst (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr),
    .hart_id_i     (hart_id_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .req_valid_o   (req_valid),
    .req           (req_if.source)
  );

  // Every unit sees the request, only its own strobe makes it act
  for (genvar h = 0; h < `VCFG_N_HARTS; h++) begin : gen_hart
    vcsr_unit vcsr_unit_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_valid_i (req_valid[h]),
      .req         (req_if.sink),
      .vtype_o     (hart_vtype[h]),
      .vl_o        (hart_vl[h]),
      .vstart_o    (hart_vstart[h])
    );
  end

  vcsr_readback vcsr_readback_inst (
    .rd_hart_i (rd_hart_i),
    .vtype_i   (hart_vtype),
    .vl_i      (hart_vl),
    .vstart_i  (hart_vstart),
    .vtype_o   (vtype_o),
    .vl_o      (vl_o),
    .vstart_o  (vstart_o)
  );

endmodule

//--- verilog/vcsr_readback.sv
// Vector CSR readback
// Selects one hart's state and packs vtype into the 32-bit CSR layout
`timescale 1ns/1ps
`include "vcfg_macros.svh"

module vcsr_readback (
  input  logic [`VCFG_HART_W-1:0] rd_hart_i,
  input  vcfg_pkg::vtype_t        vtype_i  [`VCFG_N_HARTS],
  input  vcfg_pkg::vlen_t         vl_i     [`VCFG_N_HARTS],
  input  vcfg_pkg::vlen_t         vstart_i [`VCFG_N_HARTS],
  output logic [31:0]             vtype_o,
  output vcfg_pkg::vlen_t         vl_o,
  output vcfg_pkg::vlen_t         vstart_o
);
  import vcfg_pkg::*;

  vtype_t sel_vtype;

  assign sel_vtype = vtype_i[rd_hart_i];

  // vill sits in the MSB, the other fields in the low byte
  assign vtype_o = {
    sel_vtype.vill,
    23'd0,
    sel_vtype.vma,
    sel_vtype.vta,
    sel_vtype.vsew,
    sel_vtype.vlmul
  };

  assign vl_o     = vl_i[rd_hart_i];
  assign vstart_o = vstart_i[rd_hart_i];

endmodule

//--- vcsr/vcsr_unit.sv
// Vector CSR unit of one hart
// Holds vtype, vl and vstart, checks a new vtype for legality
// and derives vl from AVL and VLMAX
`timescale 1ns/1ps
`include "vcfg_macros.svh"

module vcsr_unit (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             req_valid_i,
  vcsr_req_if.sink         req,
  output vcfg_pkg::vtype_t vtype_o,
  output vcfg_pkg::vlen_t  vl_o,
  output vcfg_pkg::vlen_t  vstart_o
);
  import vcfg_pkg::*;

  vtype_t vtype_d, vtype_q;
  vlen_t  vl_d, vl_q;
  vlen_t  vstart_d, vstart_q;

  // log2(LMUL) comes out negative for fractional settings
  logic signed [4:0] new_lmul_log;
  logic signed [4:0] old_lmul_log;
  // log2(SEW/LMUL) minus 3
  logic signed [4:0] new_ratio;
  logic signed [4:0] old_ratio;
  logic              vtype_bad;
  vlen_t             vlmax;
  vlen_t             vl_new;

  always_comb begin
    new_lmul_log = $signed({{2{req.vtype.vlmul[2]}}, req.vtype.vlmul});
    old_lmul_log = $signed({{2{vtype_q.vlmul[2]}}, vtype_q.vlmul});
    new_ratio    = $signed({2'b00, req.vtype.vsew}) - new_lmul_log;
    old_ratio    = $signed({2'b00, vtype_q.vsew}) - old_lmul_log;
    // SEW > LMUL * ELEN reduces to vsew > log2(LMUL) + 2 for ELEN 32
    vtype_bad = (req.vtype.vsew > EW_32) ||
                (req.vtype.vlmul == LMUL_RES) ||
                ($signed({2'b00, req.vtype.vsew}) > new_lmul_log + 5'sd2);
  end

  // VLMAX is VLENB / SEW bytes scaled by LMUL
  always_comb begin
    vlmax = vlen_t'(`VCFG_VLENB) >> req.vtype.vsew;
    case (req.vtype.vlmul)
      LMUL_2:  vlmax = vlmax << 1;
      LMUL_4:  vlmax = vlmax << 2;
      LMUL_8:  vlmax = vlmax << 3;
      LMUL_F2: vlmax = vlmax >> 1;
      LMUL_F4: vlmax = vlmax >> 2;
      LMUL_F8: vlmax = vlmax >> 3;
      default: vlmax = vlmax;
    endcase

    // An all-ones AVL lies above any VLMAX and so selects it
    if (req.avl < 32'(vlmax)) begin
      vl_new = vlen_t'(req.avl);
    end else begin
      vl_new = vlmax;
    end
  end

  always_comb begin
    vtype_d  = vtype_q;
    vl_d     = vl_q;
    vstart_d = vstart_q;

    if (req_valid_i) begin
      if (req.flags.reset_vstart) begin
        vstart_d = '0;
      end

      if (req.op == VCSR) begin
        if (req.flags.write_vstart) begin
          vstart_d = vlen_t'(req.avl);
        end else if (req.flags.set_vstart) begin
          vstart_d = vstart_q | vlen_t'(req.avl);
        end else if (req.flags.clear_vstart) begin
          vstart_d = vstart_q & ~vlen_t'(req.avl);
        end
      end else begin
        if (vtype_bad) begin
          vtype_d = VTYPE_ILLEGAL;
          vl_d    = '0;
        end else if (!req.flags.keep_vl) begin
          vtype_d = req.vtype;
          vl_d    = vl_new;
        end else if (new_ratio != old_ratio) begin
          // Keeping vl is only allowed at the same SEW/LMUL ratio
          vtype_d = VTYPE_ILLEGAL;
          vl_d    = '0;
        end else begin
          vtype_d = req.vtype;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vtype_q  <= VTYPE_ILLEGAL;
      vl_q     <= '0;
      vstart_q <= '0;
    end else begin
      vtype_q  <= vtype_d;
      vl_q     <= vl_d;
      vstart_q <= vstart_d;
    end
  end

  assign vtype_o  = vtype_q;
  assign vl_o     = vl_q;
  assign vstart_o = vstart_q;

endmodule

//--- verilog/vcfg_decoder.sv
// Vector configuration decoder
// Turns vsetvli, vsetvl and vstart CSR writes into a request plus
// a one-hot valid strobe for the addressed hart
`timescale 1ns/1ps
`include "vcfg_macros.svh"

module vcfg_decoder (
  input  logic                     instr_valid_i,
  input  vcfg_pkg::rvv_instr_u     instr_i,
  input  logic [`VCFG_HART_W-1:0]  hart_id_i,
  input  logic [31:0]              rs1_i,
  input  logic [31:0]              rs2_i,
  output logic [`VCFG_N_HARTS-1:0] req_valid_o,
  vcsr_req_if.source               req
);
  import vcfg_pkg::*;

  logic       is_vset;
  logic       is_vsetvli;
  logic       is_vsetvl;
  logic       is_vstart_csr;
  logic       hit;
  logic [7:0] vtype_bits;
  vtype_t     new_vtype;

  // Instruction recognition
  always_comb begin
    is_vset = (instr_i.vsetvli.opcode == OPC_VECTOR) &&
              (instr_i.vsetvli.funct3 == F3_OPCFG);
    is_vsetvli = is_vset && !instr_i.vsetvli.bit31;
    // vsetvl has bits 30 to 25 clear
    is_vsetvl = is_vset && instr_i.vsetvli.bit31 &&
                (instr_i.vsetvli.zimm[10:5] == 6'd0);
    // Same word seen as a CSR access
    is_vstart_csr = (instr_i.csr.opcode == OPC_SYSTEM) &&
                    (instr_i.csr.addr == CSR_VSTART) &&
                    ((instr_i.csr.funct3 == F3_CSRRW) ||
                     (instr_i.csr.funct3 == F3_CSRRS) ||
                     (instr_i.csr.funct3 == F3_CSRRC));
    hit = is_vsetvli || is_vsetvl || is_vstart_csr;
  end

  // New vtype from zimm or from rs2
  always_comb begin
    vtype_bits      = is_vsetvl ? rs2_i[7:0] : instr_i.vsetvli.zimm[7:0];
    new_vtype.vill  = 1'b0;
    new_vtype.vma   = vtype_bits[7];
    new_vtype.vta   = vtype_bits[6];
    new_vtype.vsew  = vew_e'(vtype_bits[5:3]);
    new_vtype.vlmul = vlmul_e'(vtype_bits[2:0]);
  end

  always_comb begin
    req.op    = VCFG;
    req.flags = '0;
    req.avl   = rs1_i;
    req.vtype = new_vtype;

    if (is_vsetvli || is_vsetvl) begin
      req.flags.reset_vstart = 1'b1;
      if (instr_i.vsetvli.rs1 == 5'd0) begin
        // rs1 = x0 asks for VLMAX, unless rd is x0 too
        if (instr_i.vsetvli.rd != 5'd0) begin
          req.avl = '1;
        end else begin
          req.flags.keep_vl = 1'b1;
        end
      end
    end else if (is_vstart_csr) begin
      req.op = VCSR;
      req.flags.write_vstart = (instr_i.csr.funct3 == F3_CSRRW);
      req.flags.set_vstart   = (instr_i.csr.funct3 == F3_CSRRS);
      req.flags.clear_vstart = (instr_i.csr.funct3 == F3_CSRRC);
    end
  end

  // Strobe only the addressed hart
  assign req_valid_o = (instr_valid_i && hit) ?
                       (`VCFG_N_HARTS'(1) << hart_id_i) : '0;

endmodule

//--- common/vcsr_req_if.sv
// Vector configuration request bundle
// Carries one decoded request from the decoder to every hart's CSR unit
`timescale 1ns/1ps

interface vcsr_req_if;
  import vcfg_pkg::*;

  vcfg_op_e    op;
  vcsr_flags_t flags;
  logic [31:0] avl;
  vtype_t      vtype;

  modport source (
    output op,
    output flags,
    output avl,
    output vtype
  );

  modport sink (
    input op,
    input flags,
    input avl,
    input vtype
  );

endinterface

//--- common/vcfg_pkg.sv
// Vector configuration package
// vtype fields, request flags and the two decodings of an instruction word
`include "vcfg_macros.svh"

package vcfg_pkg;

  typedef logic [`VCFG_VL_W-1:0] vlen_t;

  typedef enum logic [2:0] {
    EW_8  = 3'd0,
    EW_16 = 3'd1,
    EW_32 = 3'd2,
    EW_64 = 3'd3
  } vew_e;

  // Encoding follows the RVV vlmul field
  typedef enum logic [2:0] {
    LMUL_1   = 3'd0,
    LMUL_2   = 3'd1,
    LMUL_4   = 3'd2,
    LMUL_8   = 3'd3,
    LMUL_RES = 3'd4,
    LMUL_F8  = 3'd5,
    LMUL_F4  = 3'd6,
    LMUL_F2  = 3'd7
  } vlmul_e;

  typedef struct packed {
    logic   vill;
    logic   vma;
    logic   vta;
    vew_e   vsew;
    vlmul_e vlmul;
  } vtype_t;

  typedef enum logic {
    VCFG = 1'b0,
    VCSR = 1'b1
  } vcfg_op_e;

  typedef struct packed {
    logic keep_vl;
    logic reset_vstart;
    logic write_vstart;
    logic set_vstart;
    logic clear_vstart;
  } vcsr_flags_t;

  // vsetvli/vsetvl layout
  typedef struct packed {
    logic        bit31;
    logic [10:0] zimm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rvv_vsetvli_t;

  // Zicsr register form
  typedef struct packed {
    logic [11:0] addr;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rvv_csr_t;

  typedef union packed {
    rvv_vsetvli_t vsetvli;
    rvv_csr_t     csr;
  } rvv_instr_u;

  localparam logic [6:0]  OPC_VECTOR = 7'h57;
  localparam logic [6:0]  OPC_SYSTEM = 7'h73;
  localparam logic [11:0] CSR_VSTART = 12'h008;

  localparam logic [2:0] F3_OPCFG = 3'd7;
  localparam logic [2:0] F3_CSRRW = 3'd1;
  localparam logic [2:0] F3_CSRRS = 3'd2;
  localparam logic [2:0] F3_CSRRC = 3'd3;

  localparam vtype_t VTYPE_ILLEGAL = '{vill: 1'b1, vsew: EW_8, vlmul: LMUL_1, default: '0};

endpackage

//--- common/vcfg_macros.svh
// Vector configuration sizes
// Vector length, element width and hart count for the vcfg cluster
`ifndef VCFG_MACROS_SVH
`define VCFG_MACROS_SVH

// Vector register length and widest element, in bits
`define VCFG_VLEN 256
`define VCFG_ELEN 32

// VLEN in bytes
`define VCFG_VLENB (`VCFG_VLEN / 8)

// Largest vl, reached with e8 and LMUL 8
`define VCFG_MAXVL (`VCFG_VLENB * 8)
`define VCFG_VL_W 9

// Harts in the cluster
`define VCFG_N_HARTS 4
`define VCFG_HART_W 2

`endif
